/* Makefile */
VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_if_stage
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* if_fetch_addr_counter.sv */
////////////////////
// word-aligned fetch address register
// and address capture at grant
////////////////////

module if_fetch_addr_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  logic [if_pkg::XLEN-1:0] load_addr_i,
  input  logic                    grant_i,
  output logic [if_pkg::XLEN-1:0] fetch_addr_o,
  output logic [if_pkg::XLEN-1:0] resp_addr_o
);

  import if_pkg::*;

  logic [XLEN-1:0] fetch_addr_q;
  logic [XLEN-1:0] resp_addr_q;

  // a redirect wins over a grant in the same cycle
  // since the granted word is dropped anyway
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (load_i) begin
      // bus only ever sees aligned words
      fetch_addr_q <= {load_addr_i[XLEN-1:2], 2'b00};
    end else if (grant_i) begin
      fetch_addr_q <= fetch_addr_q + XLEN'(INSTR_BYTES);
    end
  end

  // address tag for the response that follows this grant
  always_ff @(posedge clk_i) begin
    if (grant_i) begin
      resp_addr_q <= fetch_addr_q;
    end
  end

  assign fetch_addr_o = fetch_addr_q;
  assign resp_addr_o  = resp_addr_q;

endmodule

/* if_fetch_ctrl.sv */
////////////////////
// request FSM for the instruction memory port
// one request outstanding at a time
////////////////////

module if_fetch_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic pc_set_i,
  input  logic fifo_full_i,
  output logic instr_req_o,
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,
  output logic grant_o,
  output logic push_o,
  output logic busy_o
);

  import if_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FETCH_IDLE: begin
        // no request in a redirect cycle, address loads first
        if (req_i && !fifo_full_i && !pc_set_i) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (instr_gnt_i) begin
          // granted word is stale if a redirect came along with it
          state_d = pc_set_i ? FETCH_DROP : FETCH_WAIT;
        end else if (pc_set_i) begin
          state_d = FETCH_IDLE;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end else if (pc_set_i) begin
          state_d = FETCH_DROP;
        end
      end
      FETCH_DROP: begin
        // wait out the response and throw it away
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign instr_req_o = (state_q == FETCH_REQ);
  // counter steps and tags on this pulse
  assign grant_o     = (state_q == FETCH_REQ) & instr_gnt_i;
  // response lands in the queue unless a redirect squashes it
  assign push_o      = (state_q == FETCH_WAIT) & instr_rvalid_i & ~pc_set_i;
  assign busy_o      = (state_q != FETCH_IDLE);

endmodule

/* if_fetch_fifo.sv */
////////////////////
// flushable circular queue, generic payload
////////////////////

module if_fetch_fifo #(
  parameter int unsigned DEPTH   = if_pkg::FIFO_DEPTH,
  parameter type         entry_t = if_pkg::fetch_entry_t
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   push_i,
  input  entry_t push_data_i,
  input  logic   pop_i,
  output entry_t head_o,
  output logic   head_valid_o,
  output logic   full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_en;
  logic             pop_en;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_incr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign head_valid_o = (count_q != '0);
  assign full_o       = (count_q == CNT_W'(DEPTH));

  // pop only real entries
  assign pop_en  = pop_i & head_valid_o;
  // a full queue still takes a push when the head leaves
  assign push_en = push_i & (~full_o | pop_en);

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect empties the queue
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_incr(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_incr(rd_ptr_q);
      end
      // count moves only when push and pop differ
      if (push_en && !pop_en) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop_en && !push_en) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_o = mem_q[rd_ptr_q];

endmodule

/* if_id_register.sv */
////////////////////
// IF-ID pipeline register, valid/new flags
// and sequential PC check
////////////////////

module if_id_register (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  if_pkg::fetch_entry_t head_i,
  input  logic                 head_valid_i,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output logic                 pop_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_pkg::id_instr_t    id_instr_o,
  output logic                 pc_mismatch_alert_o
);

  import if_pkg::*;

  id_instr_t       id_instr_q;
  logic            valid_q;
  logic            valid_d;
  logic            new_q;
  logic            new_d;
  logic            seq_q;
  logic            seq_d;
  logic [XLEN-1:0] pc_next_seq;

  // ID takes the head whenever it is ready
  assign pop_o = head_valid_i & id_in_ready_i;

  // a word taken in a redirect cycle is squashed
  assign new_d   = pop_o & ~pc_set_i;
  // valid holds until the core clears it
  assign valid_d = new_d | (valid_q & ~instr_valid_clear_i);
  // sequence tracking restarts on every redirect
  assign seq_d   = (seq_q | pop_o) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
      seq_q   <= seq_d;
    end
  end

  ////////////////////
  // pipeline register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      id_instr_q.rdata     <= head_i.rdata;
      id_instr_q.pc        <= head_i.addr;
      id_instr_q.fetch_err <= head_i.err;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign id_instr_o       = id_instr_q;

  // next word in a straight run sits one word above the ID pc
  assign pc_next_seq = id_instr_q.pc + XLEN'(INSTR_BYTES);

  // head breaking the run without a redirect means corrupted fetch
  assign pc_mismatch_alert_o = seq_q & head_valid_i & (head_i.addr != pc_next_seq);

endmodule

/* if_pc_select.sv */
////////////////////
// handler address and next fetch address mux
////////////////////

module if_pc_select (
  input  logic [if_pkg::XLEN-1:0] boot_addr_i,
  input  if_pkg::pc_ctrl_t        pc_ctrl_i,
  input  logic [if_pkg::XLEN-1:0] branch_target_i,
  input  if_pkg::csr_pc_t         csr_pc_i,
  output logic [if_pkg::XLEN-1:0] fetch_addr_n_o,
  output logic                    csr_mtvec_init_o
);

  import if_pkg::*;

  logic [XLEN-1:0] exc_pc;
  logic [XLEN-1:0] boot_pc;

  // boot page from the input, fixed offset inside it
  assign boot_pc = {boot_addr_i[XLEN-1:8], BOOT_OFFSET};

  // handler address
  // mtvec is 256-byte aligned, vectored irqs land at irq_id * 4
  always_comb begin
    unique case (pc_ctrl_i.exc_pc_mux)
      EXC_PC_EXC:     exc_pc = {csr_pc_i.mtvec[XLEN-1:8], 8'h00};
      EXC_PC_IRQ:     exc_pc = {csr_pc_i.mtvec[XLEN-1:8], 1'b0, pc_ctrl_i.irq_id, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {csr_pc_i.mtvec[XLEN-1:8], 8'h00};
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_ctrl_i.pc_mux)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n_o = csr_pc_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_n_o = csr_pc_i.depc;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file sets mtvec up on the boot jump
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_mux == PC_BOOT);

endmodule

/* if_pkg.sv */
////////////////////
// shared constants, selector enums and payload structs
// for the instruction fetch stage
////////////////////

package if_pkg;

  ////////////////////
  // constants
  ////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // every instruction is a full word
  localparam int unsigned INSTR_BYTES = 4;
  // boot entry sits at this offset inside the boot page
  localparam logic [7:0] BOOT_OFFSET = 8'h80;
  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR  = 32'h1A11_0808;
  // fetched words buffered between the bus and ID
  localparam int unsigned FIFO_DEPTH = 2;

  ////////////////////
  // enums
  ////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the handler address when pc_mux is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // memory request port states
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_REQ  = 2'd1,
    FETCH_WAIT = 2'd2,
    FETCH_DROP = 2'd3
  } fetch_state_e;

  ////////////////////
  // structs
  ////////////////////

  // csr values the fetch stage can jump to
  typedef struct packed {
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] depc;
    logic [XLEN-1:0] mtvec;
  } csr_pc_t;

  // redirect request from the controller
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [4:0]  irq_id;
  } pc_ctrl_t;

  // one fetched word, tagged with its address
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic            err;
  } fetch_entry_t;

  // contents of the IF-ID pipeline register
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] pc;
    logic            fetch_err;
  } id_instr_t;

endpackage

/* if_stage.sv */
////////////////////
// instruction fetch stage top level
////////////////////

module if_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [if_pkg::XLEN-1:0] boot_addr_i,
  input  logic                    req_i,
  input  if_pkg::pc_ctrl_t        pc_ctrl_i,
  input  logic [if_pkg::XLEN-1:0] branch_target_i,
  input  if_pkg::csr_pc_t         csr_pc_i,
  input  logic                    id_in_ready_i,
  input  logic                    instr_valid_clear_i,

  // instruction memory port
  output logic                    instr_req_o,
  output logic [if_pkg::XLEN-1:0] instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                    instr_err_i,

  // towards ID
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output if_pkg::id_instr_t       id_instr_o,
  output logic [if_pkg::XLEN-1:0] pc_if_o,
  output logic                    csr_mtvec_init_o,
  output logic                    pc_mismatch_alert_o,
  output logic                    if_busy_o
);

  import if_pkg::*;

  logic            pc_set;
  logic [XLEN-1:0] fetch_addr_n;
  logic [XLEN-1:0] resp_addr;
  logic            grant;
  logic            push;
  logic            pop;
  logic            fifo_full;
  logic            head_valid;
  fetch_entry_t    push_entry;
  fetch_entry_t    head;

  assign pc_set = pc_ctrl_i.pc_set;

  // response tagged with the address granted for it
  assign push_entry = '{rdata: instr_rdata_i, addr: resp_addr, err: instr_err_i};

  assign pc_if_o = head.addr;

  if_pc_select u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_ctrl_i        (pc_ctrl_i),
    .branch_target_i  (branch_target_i),
    .csr_pc_i         (csr_pc_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_fetch_addr_counter u_addr_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (pc_set),
    .load_addr_i  (fetch_addr_n),
    .grant_i      (grant),
    .fetch_addr_o (instr_addr_o),
    .resp_addr_o  (resp_addr)
  );

  if_fetch_ctrl u_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set),
    .fifo_full_i    (fifo_full),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .grant_o        (grant),
    .push_o         (push),
    .busy_o         (if_busy_o)
  );

  // fetched words wait here until ID takes them
  if_fetch_fifo #(
    .DEPTH   (FIFO_DEPTH),
    .entry_t (fetch_entry_t)
  ) u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (pc_set),
    .push_i       (push),
    .push_data_i  (push_entry),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .full_o       (fifo_full)
  );

  if_id_register u_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .head_i              (head),
    .head_valid_i        (head_valid),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pop_o               (pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

/* list.f */
if_pkg.sv
if_pc_select.sv
if_fetch_addr_counter.sv
if_fetch_ctrl.sv
if_fetch_fifo.sv
if_id_register.sv
if_stage.sv
tb_if_stage.sv

/* tb_if_stage.sv */
////////////////////
// testbench for the fetch stage: memory model,
// random stimulus, reference pc model and checks
////////////////////

module tb_if_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import if_pkg::*;

  logic                clk_i;
  logic                rst_ni;
  logic [XLEN-1:0]     boot_addr_i;
  logic                req_i;
  pc_ctrl_t            pc_ctrl_i;
  logic [XLEN-1:0]     branch_target_i;
  csr_pc_t             csr_pc_i;
  logic                id_in_ready_i;
  logic                instr_valid_clear_i;
  logic                instr_req_o;
  logic [XLEN-1:0]     instr_addr_o;
  logic                instr_gnt_i = 1'b0;
  logic                instr_rvalid_i = 1'b0;
  logic [XLEN-1:0]     instr_rdata_i = '0;
  logic                instr_err_i = 1'b0;
  logic                instr_valid_id_o;
  logic                instr_new_id_o;
  id_instr_t           id_instr_o;
  logic [XLEN-1:0]     pc_if_o;
  logic                csr_mtvec_init_o;
  logic                pc_mismatch_alert_o;
  logic                if_busy_o;

  // separate random streams for stimulus and memory
  logic [31:0] stim_seed = 32'd34248;
  logic [31:0] mem_seed = 32'd34248;

  int unsigned check_count = 0;
  int unsigned error_count = 0;
  int unsigned errors_at_test_start = 0;

  if_stage dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // value in 0 .. span-1 from the stimulus stream
  function automatic logic [31:0] draw_stim(input logic [31:0] span);
    stim_seed = lcg_step(stim_seed);
    return (stim_seed >> 16) % span;
  endfunction

  function automatic logic [31:0] draw_mem(input logic [31:0] span);
    mem_seed = lcg_step(mem_seed);
    return (mem_seed >> 16) % span;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = draw_stim(32'h1_0000);
    lo = draw_stim(32'h1_0000);
    return {hi[15:0], lo[15:0]};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished, %0d errors", name, error_count - errors_at_test_start);
    errors_at_test_start = error_count;
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // next fetch address from the redirect request, word aligned
  function automatic logic [31:0] expected_fetch_pc(input pc_ctrl_t ctrl,
                                                    input logic [31:0] boot,
                                                    input logic [31:0] target,
                                                    input csr_pc_t csr);
    logic [31:0] pc;
    logic [31:0] vec_base;
    vec_base = {csr.mtvec[31:8], 8'h00};
    case (ctrl.pc_mux)
      PC_BOOT: pc = {boot[31:8], 8'h80};
      PC_JUMP: pc = target;
      PC_EXC: begin
        case (ctrl.exc_pc_mux)
          EXC_PC_IRQ:     pc = vec_base + 32'(ctrl.irq_id) * 32'd4;
          EXC_PC_DBD:     pc = 32'h1A11_0800;
          EXC_PC_DBG_EXC: pc = 32'h1A11_0808;
          default:        pc = vec_base;
        endcase
      end
      PC_ERET: pc = csr.mepc;
      PC_DRET: pc = csr.depc;
      default: pc = 32'h0;
    endcase
    return {pc[31:2], 2'b00};
  endfunction

  logic [31:0] exp_pc = '0;
  logic [31:0] last_pc = '0;
  logic [31:0] last_rdata = '0;
  logic [31:0] prev_pc_if = '0;
  logic        prev_valid = 1'b0;
  logic        prev_clear = 1'b0;
  int unsigned new_count = 0;
  int unsigned err_count = 0;
  int unsigned mtvec_count = 0;

  // samples the cycle that ends at this edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
            32'(pc_ctrl_i.pc_set && (pc_ctrl_i.pc_mux == PC_BOOT)));
      if (csr_mtvec_init_o) begin
        mtvec_count++;
      end
      check("pc_mismatch_alert_o", 32'(pc_mismatch_alert_o), 32'd0);
      // valid set by a new word, held until a clear
      check("instr_valid_id_o", 32'(instr_valid_id_o),
            32'(instr_new_id_o | (prev_valid & ~prev_clear)));
      // a word arriving in a redirect cycle still belongs to the old stream
      if (instr_new_id_o) begin
        // head address in the accept cycle
        check("pc_if_o", prev_pc_if, exp_pc);
        check("id_instr_o.pc", id_instr_o.pc, exp_pc);
        check("id_instr_o.rdata", id_instr_o.rdata, ~exp_pc);
        check("id_instr_o.fetch_err", 32'(id_instr_o.fetch_err), 32'(&exp_pc[11:8]));
        last_pc = id_instr_o.pc;
        last_rdata = id_instr_o.rdata;
        new_count++;
        if (id_instr_o.fetch_err) begin
          err_count++;
        end
        exp_pc = exp_pc + 32'd4;
      end
      if (pc_ctrl_i.pc_set) begin
        exp_pc = expected_fetch_pc(pc_ctrl_i, boot_addr_i, branch_target_i, csr_pc_i);
      end
      prev_valid = instr_valid_id_o;
      prev_clear = instr_valid_clear_i;
      prev_pc_if = pc_if_o;
    end
  end

  ////////////////////
  // memory model
  ////////////////////

  int unsigned gnt_delay = 0;
  int unsigned resp_delay = 0;
  logic        resp_pending = 1'b0;
  logic [31:0] resp_addr = '0;
  logic        req_q = 1'b0;
  logic        gnt_q = 1'b0;
  logic [31:0] addr_q = '0;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i <= 1'b0;
      instr_rvalid_i <= 1'b0;
      resp_pending = 1'b0;
      gnt_delay = 0;
      req_q = 1'b0;
      gnt_q = 1'b0;
    end else begin
      // one request in flight, steady address until grant
      if (resp_pending || instr_rvalid_i) begin
        check("instr_req_o", 32'(instr_req_o), 32'd0);
      end
      if (req_q && !gnt_q && instr_req_o) begin
        check("instr_addr_o", instr_addr_o, addr_q);
      end
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        // grant taken here, response 1 to 3 cycles later
        resp_pending = 1'b1;
        resp_addr = instr_addr_o;
        resp_delay = draw_mem(32'd3);
        gnt_delay = draw_mem(32'd4);
        instr_gnt_i <= (gnt_delay == 0);
      end else if (instr_req_o) begin
        if (gnt_delay != 0) begin
          gnt_delay = gnt_delay - 1;
        end
        instr_gnt_i <= (gnt_delay == 0);
      end
      if (resp_pending) begin
        if (resp_delay == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i <= ~resp_addr;
          instr_err_i <= &resp_addr[11:8];
          resp_pending = 1'b0;
        end else begin
          resp_delay = resp_delay - 1;
        end
      end
      req_q = instr_req_o;
      gnt_q = instr_gnt_i;
      addr_q = instr_addr_o;
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  // one-cycle pc_set pulse with fresh csr values
  task automatic redirect(input pc_sel_e mux, input exc_pc_sel_e exc,
                          input logic [4:0] irq, input logic [31:0] target);
    @(posedge clk_i);
    branch_target_i <= target;
    csr_pc_i <= '{mepc: random_word(), depc: random_word(), mtvec: random_word()};
    pc_ctrl_i <= '{pc_set: 1'b1, pc_mux: mux, exc_pc_mux: exc, irq_id: irq};
    @(posedge clk_i);
    pc_ctrl_i.pc_set <= 1'b0;
  endtask

  task automatic wait_new_words(input int unsigned n, input int unsigned limit);
    int unsigned target;
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    target = new_count + n;
    while (new_count < target) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout("no new instruction reached ID");
      end
    end
  endtask

  task automatic wait_fetch_idle(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (if_busy_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout("fetch stage stayed busy with req_i low");
      end
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  int unsigned err_before;
  logic [31:0] boot_pc;

  initial begin
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_ctrl_i = '0;
    boot_addr_i = 32'h0000_1000;
    branch_target_i = '0;
    csr_pc_i = '0;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // boot
    @(negedge clk_i);
    check("instr_req_o", 32'(instr_req_o), 32'd0);
    check("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    check("instr_new_id_o", 32'(instr_new_id_o), 32'd0);
    check("pc_mismatch_alert_o", 32'(pc_mismatch_alert_o), 32'd0);
    check("if_busy_o", 32'(if_busy_o), 32'd0);
    @(posedge clk_i);
    req_i <= 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, 5'd0, 32'h0);
    wait_new_words(1, 100);
    boot_pc = {boot_addr_i[31:8], 8'h80};
    check("csr_mtvec_init_o pulses", 32'(mtvec_count), 32'd1);
    check("first pc", last_pc, boot_pc);
    check("first rdata", last_rdata, ~boot_pc);
    finish_test("boot");

    // straight-line stream
    wait_new_words(30, 400);
    finish_test("sequential");

    // every pc_mux and handler source, some back to back
    for (int i = 0; i < 40; i++) begin
      repeat (draw_stim(32'd6)) @(posedge clk_i);
      redirect(pc_sel_e'(3'(i % 5)), exc_pc_sel_e'(2'((i / 5) % 4)),
               5'(draw_stim(32'd32)), random_word());
      if (draw_stim(32'd4) != 0) begin
        wait_new_words(1, 100);
      end
    end
    wait_new_words(2, 100);
    finish_test("redirects");

    // random stalls and clears from ID
    repeat (400) begin
      @(posedge clk_i);
      id_in_ready_i <= (draw_stim(32'd2) == 0);
      instr_valid_clear_i <= (draw_stim(32'd4) == 0);
    end
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    instr_valid_clear_i <= 1'b0;
    wait_new_words(4, 100);
    finish_test("back-pressure");

    // into the error page and out of it again
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_0EF8);
    @(negedge clk_i);
    err_before = err_count;
    wait_new_words(4, 100);
    check("fetch errors entering 0xF00", 32'(err_count - err_before), 32'd2);
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_0FF8);
    @(negedge clk_i);
    err_before = err_count;
    wait_new_words(4, 100);
    check("fetch errors leaving 0xFFC", 32'(err_count - err_before), 32'd2);
    finish_test("fetch error");

    // no new requests once req_i drops
    @(posedge clk_i);
    req_i <= 1'b0;
    wait_fetch_idle(50);
    repeat (20) begin
      @(negedge clk_i);
      check("instr_req_o", 32'(instr_req_o), 32'd0);
      check("if_busy_o", 32'(if_busy_o), 32'd0);
    end
    finish_test("idle");

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
